/* source/datapath_memory_macros.svh */
// ------------------------------------------------
// Sizes and address map of the datapath memories
// Bank write ranges must be power-of-two aligned,
// since the banks keep only the low address bits
// Address 0 is the zero register, keep I/O off it
// ------------------------------------------------

`ifndef DATAPATH_MEMORY_MACROS_SVH
`define DATAPATH_MEMORY_MACROS_SVH

// Word and address widths
`define DM_WORD_WIDTH           16
`define DM_READ_ADDR_WIDTH      10
`define DM_WRITE_ADDR_WIDTH     12
`define DM_MEM_ADDR_WIDTH       10

// Write ranges, one per bank
`define DM_WRITE_BASE_A         0
`define DM_WRITE_BOUND_A        1023
`define DM_WRITE_BASE_B         1024
`define DM_WRITE_BOUND_B        2047

// Memory-mapped I/O ports per bank
`define DM_IO_PORT_COUNT        4
`define DM_IO_PORT_ADDR_WIDTH   2

// Pipeline stages between write address and write data
`define DM_WRITE_RETIME_STAGES  2

`endif

/* source/datapath_memory_pkg.sv */
// ------------------------------------------------
// Types shared by the datapath memory stage
// Struct layouts set the bit order on every port
// ------------------------------------------------

`default_nettype none

`include "datapath_memory_macros.svh"

package datapath_memory_pkg;

    typedef logic [`DM_WORD_WIDTH-1:0] word_t;

    // Status of the instruction that owns a write
    typedef struct packed {
        logic ior;
        logic cancel;
    } instr_status_t;

    typedef struct packed {
        logic [`DM_READ_ADDR_WIDTH-1:0] addr;
        logic                           addr_is_io;
    } mem_read_req_t;

    typedef struct packed {
        logic [`DM_WRITE_ADDR_WIDTH-1:0] addr;
        logic                            addr_is_io;
    } mem_write_req_t;

    // Everything that travels down the write retime pipeline
    typedef struct packed {
        mem_write_req_t write_a;
        mem_write_req_t write_b;
        instr_status_t  status;
    } write_retime_t;

    typedef word_t [`DM_IO_PORT_COUNT-1:0] io_bus_t;
    typedef logic  [`DM_IO_PORT_COUNT-1:0] io_wren_t;

endpackage

`default_nettype wire

/* source/write_retime_line.sv */
// ------------------------------------------------
// Fixed delay for write requests and their status
// DEPTH of 0 passes the input straight through
// Reset empties every stage, status included
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module write_retime_line
    import datapath_memory_pkg::*;
#(
    parameter int DEPTH = 2
)
(
    input  wire                clock,
    input  wire                reset,
    input  wire write_retime_t in,
    output write_retime_t      out
);

    generate
        if (DEPTH == 0) begin : g_pass
            assign out = in;
        end else begin : g_chain
            write_retime_t stage [DEPTH];

            // A cleared stage has ior low, so it never commits
            always_ff @(posedge clock) begin
                if (reset) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage[i] <= '0;
                    end
                end else begin
                    stage[0] <= in;
                    for (int i = 1; i < DEPTH; i++) begin
                        stage[i] <= stage[i-1];
                    end
                end
            end

            assign out = stage[DEPTH-1];
        end
    endgenerate

endmodule

`default_nettype wire

/* source/data_memory.sv */
// ------------------------------------------------
// One operand bank: RAM plus memory-mapped I/O
// Read to write collision returns the old word
// RAM powers up zero and ignores reset
// Write inputs must already be retimed
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "datapath_memory_macros.svh"

module data_memory
    import datapath_memory_pkg::*;
(
    input  wire                          clock,
    input  wire                          reset,

    // Operand read, result one cycle later
    input  wire                          read_enable,
    input  wire mem_read_req_t           read_req,
    input  wire io_bus_t                 io_read_data,
    output word_t                        read_data,

    // Result write
    input  wire                          write_enable,
    input  wire [`DM_MEM_ADDR_WIDTH-1:0] write_addr,
    input  wire                          write_addr_is_io,
    input  wire instr_status_t           write_status,
    input  wire word_t                   write_data,
    output io_wren_t                     io_wren,
    output io_bus_t                      io_write_data
);

    localparam int MEM_DEPTH = 1 << `DM_MEM_ADDR_WIDTH;

    word_t ram [MEM_DEPTH] = '{default: '0};

    logic [`DM_MEM_ADDR_WIDTH-1:0]     read_addr_local;
    logic [`DM_IO_PORT_ADDR_WIDTH-1:0] read_port;
    logic [`DM_IO_PORT_ADDR_WIDTH-1:0] write_port;

    word_t ram_read_data;
    word_t io_read_word;
    logic  read_sel_ram;
    logic  read_sel_io;

    logic  write_commit;
    logic  write_ram;
    logic  write_io;

// ------------------------------------------------
// Write decision
// ------------------------------------------------

    // Annulled or not-ready instructions write nothing
    assign write_commit = write_status.ior && !write_status.cancel;

    // I/O writes skip the range check
    assign write_io   = write_commit && write_addr_is_io;
    assign write_ram  = write_commit && !write_addr_is_io && write_enable;
    assign write_port = write_addr[`DM_IO_PORT_ADDR_WIDTH-1:0];

// ------------------------------------------------
// RAM
// ------------------------------------------------

    assign read_addr_local = read_req.addr[`DM_MEM_ADDR_WIDTH-1:0];
    assign read_port       = read_req.addr[`DM_IO_PORT_ADDR_WIDTH-1:0];

    always_ff @(posedge clock) begin
        if (write_ram) begin
            ram[write_addr] <= write_data;
        end
        ram_read_data <= ram[read_addr_local];
    end

// ------------------------------------------------
// Read source selection
// ------------------------------------------------

    // Both selects low means the zero register
    always_ff @(posedge clock) begin
        if (reset) begin
            read_sel_ram <= 1'b0;
            read_sel_io  <= 1'b0;
        end else begin
            read_sel_ram <= read_enable && !read_req.addr_is_io;
            read_sel_io  <= read_enable &&  read_req.addr_is_io;
        end
    end

    // I/O input captured on the same edge as the RAM read
    always_ff @(posedge clock) begin
        io_read_word <= io_read_data[read_port];
    end

    always_comb begin
        if (read_sel_io) begin
            read_data = io_read_word;
        end else if (read_sel_ram) begin
            read_data = ram_read_data;
        end else begin
            read_data = '0;
        end
    end

// ------------------------------------------------
// I/O write ports
// ------------------------------------------------

    // Enable is a single-cycle pulse, data holds until the next write
    always_ff @(posedge clock) begin
        if (reset) begin
            io_wren       <= '0;
            io_write_data <= '0;
        end else begin
            io_wren <= '0;
            if (write_io) begin
                io_wren[write_port]       <= 1'b1;
                io_write_data[write_port] <= write_data;
            end
        end
    end

endmodule

`default_nettype wire

/* source/datapath_memory.sv */
// ------------------------------------------------
// Data memory stage for operand banks A and B
// Write data arrives already aligned to the
// retimed write address; it is not delayed here
// Bank ranges are decoded after retiming
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "datapath_memory_macros.svh"

module datapath_memory
    import datapath_memory_pkg::*;
(
    input  wire                 clock,
    input  wire                 reset,

    // Status of the current instruction
    input  wire instr_status_t  status,

    input  wire mem_read_req_t  read_req_a,
    input  wire mem_read_req_t  read_req_b,
    input  wire mem_write_req_t write_req_a,
    input  wire mem_write_req_t write_req_b,

    // From the ALU
    input  wire word_t          write_data_a,
    input  wire word_t          write_data_b,

    // I/O ports
    input  wire io_bus_t        io_read_data_a,
    input  wire io_bus_t        io_read_data_b,

    output word_t               read_data_a,
    output word_t               read_data_b,
    output io_wren_t            io_wren_a,
    output io_wren_t            io_wren_b,
    output io_bus_t             io_write_data_a,
    output io_bus_t             io_write_data_b
);

    write_retime_t retime_in;
    write_retime_t retime_out;

    logic write_enable_a;
    logic write_enable_b;
    logic read_enable_a;
    logic read_enable_b;

    logic [`DM_MEM_ADDR_WIDTH-1:0] write_addr_a_local;
    logic [`DM_MEM_ADDR_WIDTH-1:0] write_addr_b_local;

// ------------------------------------------------
// Write retiming
// ------------------------------------------------

    assign retime_in.write_a = write_req_a;
    assign retime_in.write_b = write_req_b;
    assign retime_in.status  = status;

    write_retime_line #(
        .DEPTH (`DM_WRITE_RETIME_STAGES)
    ) retime (
        .clock (clock),
        .reset (reset),
        .in    (retime_in),
        .out   (retime_out)
    );

// ------------------------------------------------
// Address decoding
// ------------------------------------------------

    assign write_enable_a = (retime_out.write_a.addr >= `DM_WRITE_BASE_A)
                         && (retime_out.write_a.addr <= `DM_WRITE_BOUND_A);
    assign write_enable_b = (retime_out.write_b.addr >= `DM_WRITE_BASE_B)
                         && (retime_out.write_b.addr <= `DM_WRITE_BOUND_B);

    // Address 0 reads as zero in both banks
    assign read_enable_a = (read_req_a.addr != '0);
    assign read_enable_b = (read_req_b.addr != '0);

    // Banks only see their local offset; read trimming happens in the bank
    assign write_addr_a_local = retime_out.write_a.addr[`DM_MEM_ADDR_WIDTH-1:0];
    assign write_addr_b_local = retime_out.write_b.addr[`DM_MEM_ADDR_WIDTH-1:0];

// ------------------------------------------------
// Banks
// ------------------------------------------------

    data_memory bank_a (
        .clock            (clock),
        .reset            (reset),
        .read_enable      (read_enable_a),
        .read_req         (read_req_a),
        .io_read_data     (io_read_data_a),
        .read_data        (read_data_a),
        .write_enable     (write_enable_a),
        .write_addr       (write_addr_a_local),
        .write_addr_is_io (retime_out.write_a.addr_is_io),
        .write_status     (retime_out.status),
        .write_data       (write_data_a),
        .io_wren          (io_wren_a),
        .io_write_data    (io_write_data_a)
    );

    data_memory bank_b (
        .clock            (clock),
        .reset            (reset),
        .read_enable      (read_enable_b),
        .read_req         (read_req_b),
        .io_read_data     (io_read_data_b),
        .read_data        (read_data_b),
        .write_enable     (write_enable_b),
        .write_addr       (write_addr_b_local),
        .write_addr_is_io (retime_out.write_b.addr_is_io),
        .write_status     (retime_out.status),
        .write_data       (write_data_b),
        .io_wren          (io_wren_b),
        .io_write_data    (io_write_data_b)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// ------------------------------------------------
// Free-running testbench clock, starts low
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
)
(
    output logic clock
);

    initial clock = 1'b0;

    always #(PERIOD_NS / 2) clock = ~clock;

endmodule

`default_nettype wire

/* testbench/datapath_memory_tb.sv */
// ------------------------------------------------
// Random test of both banks against a cycle model
// Inputs change 2 ns after the rising edge
// Stops at the first mismatch
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "datapath_memory_macros.svh"

module datapath_memory_tb
    import datapath_memory_pkg::*;
;

    localparam int  CLOCK_PERIOD  = 40;
    localparam int  RESET_CYCLES  = 4;
    localparam int  RANDOM_CYCLES = 2000;
    localparam int  STAGES        = `DM_WRITE_RETIME_STAGES;
    localparam time WATCHDOG_NS   = (RANDOM_CYCLES + 20) * CLOCK_PERIOD * 2;

    logic clock;
    logic reset;
    instr_status_t  status;
    mem_read_req_t  read_req_a, read_req_b;
    mem_write_req_t write_req_a, write_req_b;
    word_t          write_data_a, write_data_b;
    io_bus_t        io_read_data_a, io_read_data_b;
    word_t          read_data_a, read_data_b;
    io_wren_t       io_wren_a, io_wren_b;
    io_bus_t        io_write_data_a, io_write_data_b;

    logic [31:0] lfsr_state;

    // Reference model state, index 0 is bank A
    word_t         model_ram [2][1 << `DM_MEM_ADDR_WIDTH];
    io_bus_t       model_io [2];
    word_t         exp_read [2];
    io_wren_t      exp_wren [2];
    write_retime_t pending [$];

    tb_clock_gen #(.PERIOD_NS(CLOCK_PERIOD)) clock_gen (.clock(clock));

    datapath_memory uut (.*);

// ------------------------------------------------
// Random numbers
// ------------------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Mostly low addresses so reads revisit recent writes
    function automatic mem_read_req_t random_read();
        mem_read_req_t req;
        req.addr       = (take_bits(2) != 0) ? 10'(take_bits(3)) : 10'(take_bits(10));
        req.addr_is_io = (take_bits(3) == 0);
        return req;
    endfunction

    function automatic mem_write_req_t random_write(input int bank);
        mem_write_req_t req;
        logic [1:0]     kind;
        int             base;
        base = (bank == 0) ? `DM_WRITE_BASE_A : `DM_WRITE_BASE_B;
        kind = 2'(take_bits(2));
        case (kind)
            2'd2:    req.addr = 12'(take_bits(12));
            2'd3:    req.addr = 12'(base + int'(take_bits(10)));
            default: req.addr = 12'(base + int'(take_bits(3)));
        endcase
        req.addr_is_io = (take_bits(3) == 0);
        return req;
    endfunction

    task automatic drive_random();
        status.ior    = (take_bits(2) != 0);
        status.cancel = (take_bits(2) == 0);
        read_req_a    = random_read();
        read_req_b    = random_read();
        write_req_a   = random_write(0);
        write_req_b   = random_write(1);
        write_data_a  = word_t'(take_bits(16));
        write_data_b  = word_t'(take_bits(16));
        for (int p = 0; p < `DM_IO_PORT_COUNT; p++) begin
            io_read_data_a[p] = word_t'(take_bits(16));
            io_read_data_b[p] = word_t'(take_bits(16));
        end
    endtask

// ------------------------------------------------
// Reference model
// ------------------------------------------------

    task automatic apply_bank(input int bank, input mem_read_req_t rd, input io_bus_t io_in,
                              input mem_write_req_t wr, input instr_status_t st,
                              input word_t wdata);
        int lo;
        int hi;
        lo = (bank == 0) ? `DM_WRITE_BASE_A : `DM_WRITE_BASE_B;
        hi = (bank == 0) ? `DM_WRITE_BOUND_A : `DM_WRITE_BOUND_B;
        // Read sees the RAM before this edge's write
        if (rd.addr == 0) begin
            exp_read[bank] = '0;
        end else if (rd.addr_is_io) begin
            exp_read[bank] = io_in[rd.addr[`DM_IO_PORT_ADDR_WIDTH-1:0]];
        end else begin
            exp_read[bank] = model_ram[bank][rd.addr];
        end
        exp_wren[bank] = '0;
        if (st.ior && !st.cancel) begin
            if (wr.addr_is_io) begin
                exp_wren[bank][wr.addr[`DM_IO_PORT_ADDR_WIDTH-1:0]] = 1'b1;
                model_io[bank][wr.addr[`DM_IO_PORT_ADDR_WIDTH-1:0]] = wdata;
            end else if (int'(wr.addr) >= lo && int'(wr.addr) <= hi) begin
                model_ram[bank][wr.addr[`DM_MEM_ADDR_WIDTH-1:0]] = wdata;
            end
        end
    endtask

    // Called at each rising edge with the inputs that were just sampled
    task automatic update_model();
        write_retime_t incoming;
        write_retime_t matured;
        incoming.write_a = write_req_a;
        incoming.write_b = write_req_b;
        incoming.status  = status;
        if (reset) begin
            pending.delete();
            repeat (STAGES) pending.push_back('0);
            for (int b = 0; b < 2; b++) begin
                exp_read[b] = '0;
                exp_wren[b] = '0;
                model_io[b] = '0;
            end
        end else begin
            matured = pending.pop_front();
            pending.push_back(incoming);
            apply_bank(0, read_req_a, io_read_data_a, matured.write_a, matured.status,
                       write_data_a);
            apply_bank(1, read_req_b, io_read_data_b, matured.write_b, matured.status,
                       write_data_b);
        end
    endtask

// ------------------------------------------------
// Checking
// ------------------------------------------------

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                     $time);
            $display(">>> FAIL");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic check_outputs();
        check_value("read_data_a", read_data_a, exp_read[0]);
        check_value("read_data_b", read_data_b, exp_read[1]);
        check_value("io_wren_a", io_wren_a, exp_wren[0]);
        check_value("io_wren_b", io_wren_b, exp_wren[1]);
        check_value("io_write_data_a", io_write_data_a, model_io[0]);
        check_value("io_write_data_b", io_write_data_b, model_io[1]);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run took longer than the test length allows");
        $display(">>> FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        lfsr_state     = 32'h22ed0ba3;
        reset          = 1'b1;
        status         = '0;
        read_req_a     = '0;
        read_req_b     = '0;
        write_req_a    = '0;
        write_req_b    = '0;
        write_data_a   = '0;
        write_data_b   = '0;
        io_read_data_a = '0;
        io_read_data_b = '0;
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < (1 << `DM_MEM_ADDR_WIDTH); a++) begin
                model_ram[b][a] = '0;
            end
        end

        for (int cycle = 0; cycle < RESET_CYCLES + RANDOM_CYCLES; cycle++) begin
            @(posedge clock);
            update_model();
            #1;
            check_outputs();
            #1;
            if (cycle >= RESET_CYCLES - 1) begin
                reset = 1'b0;
                drive_random();
            end
        end
        @(posedge clock);
        update_model();
        #1;
        check_outputs();

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* datapath_memory.f */
+incdir+source
source/datapath_memory_pkg.sv
source/write_retime_line.sv
source/data_memory.sv
source/datapath_memory.sv
testbench/tb_clock_gen.sv
testbench/datapath_memory_tb.sv
